//--- hw/rv_core_pkg.sv
/*
 * shared widths, reset address and opcode/funct3 codes
 * ALU, shift-kind and sequencer enums
 * decoded instruction and data request structs
 */
package rv_core_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// first fetch address, and the instruction register contents out of reset
	localparam word_t reset_pc = 32'h8000_0000;
	localparam word_t nop_instr = 32'h0000_0013;

	// major opcodes
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;

	// arithmetic funct3
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;

	// branch compare kind, funct3[2:1]
	localparam logic [1:0] cmp_eq = 2'b00;
	localparam logic [1:0] cmp_lt = 2'b10;
	localparam logic [1:0] cmp_ltu = 2'b11;

	// access size, funct3[1:0]
	localparam logic [1:0] size_byte = 2'b00;
	localparam logic [1:0] size_half = 2'b01;

	typedef enum logic [1:0] {alu_add, alu_and, alu_or, alu_xor} alu_op_e;
	typedef enum logic [1:0] {shift_sll, shift_srl, shift_sra} shift_kind_e;
	typedef enum logic [2:0] {st_fetch, st_decode, st_execute, st_shift, st_mem} seq_state_e;

	typedef struct packed {
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_arith_imm;
		logic is_arith_reg;
		logic is_shift;
		logic is_jal;
		logic is_jalr;
		logic is_lui;
		logic is_auipc;
		logic [2:0] funct3;
		logic alt;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t imm;
	} decoded_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic [3:0] strb;
		logic write;
	} dmem_req_t;

endpackage

//--- hw/rv_sequencer.sv
/*
 * instruction sequencer FSM and program counter
 * next-pc choice, fetch/data valid strobes, register write enable
 */
`timescale 1ns/1ns

module rv_sequencer (
	input logic clock,
	input logic reset,
	input rv_core_pkg::decoded_t dec,
	input logic iready,
	input logic dready,
	input logic shift_done,
	input logic cmp_true,
	input rv_core_pkg::word_t alu_out,
	output rv_core_pkg::seq_state_e state,
	output rv_core_pkg::word_t pc,
	output logic ivalid,
	output logic dvalid,
	output logic rd_wen
);
	import rv_core_pkg::*;

	seq_state_e next_state;
	word_t next_pc;
	logic mem_op;
	logic take_jump;
	logic pc_step;

	assign mem_op = dec.is_load || dec.is_store;
	assign take_jump = dec.is_jal || dec.is_jalr || (dec.is_branch && cmp_true);

	// jump targets always land on a word boundary
	assign next_pc = take_jump ? {alu_out[xlen-1:2], 2'b00} : pc + 32'd4;

	// pc moves on the last cycle of each instruction
	assign pc_step = (state == st_execute && !mem_op) || (state == st_mem && dready);

	always_comb begin
		next_state = state;
		case (state)
			st_fetch:
				if (ivalid && iready) begin
					next_state = st_decode;
				end
			st_decode:
				next_state = dec.is_shift ? st_shift : st_execute;
			st_shift:
				if (shift_done) begin
					next_state = st_execute;
				end
			st_execute:
				next_state = mem_op ? st_mem : st_fetch;
			st_mem:
				if (dready) begin
					next_state = st_fetch;
				end
			default:
				next_state = st_fetch;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_fetch;
			pc <= reset_pc;
			ivalid <= 1'b0;
		end else begin
			state <= next_state;
			// registered so the request stays low through reset
			ivalid <= (next_state == st_fetch);
			if (pc_step) begin
				pc <= next_pc;
			end
		end
	end

	assign dvalid = (state == st_mem);

	// loads write back on the data transfer, x0 never written
	assign rd_wen = (dec.rd != '0) &&
		((state == st_execute && !mem_op && !dec.is_branch) ||
		(state == st_mem && dec.is_load && dready));

	// only one port requests at a time
	a_one_valid: assert property (@(posedge clock) disable iff (reset)
		!(ivalid && dvalid));

	// data request and its address held until accepted
	a_dvalid_hold: assert property (@(posedge clock) disable iff (reset)
		(dvalid && !dready) |=> (dvalid && $stable(alu_out)));

endmodule

//--- hw/rv_decode.sv
/*
 * instruction register and opcode classification
 * I, S, B, U and J immediate extraction into the decoded struct
 */
`timescale 1ns/1ns

module rv_decode (
	input logic clock,
	input logic reset,
	input rv_core_pkg::seq_state_e state,
	input rv_core_pkg::word_t idata,
	input logic iready,
	output rv_core_pkg::decoded_t dec
);
	import rv_core_pkg::*;

	word_t instr;
	logic [6:0] opcode;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	// last capture in fetch is the accepted word
	always_ff @(posedge clock) begin
		if (reset) begin
			instr <= nop_instr;
		end else if (state == st_fetch && iready) begin
			instr <= idata;
		end
	end

	assign opcode = instr[6:0];

	// sign-extended immediate formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		dec.is_load = (opcode == op_load);
		dec.is_store = (opcode == op_store);
		dec.is_branch = (opcode == op_branch);
		dec.is_arith_imm = (opcode == op_imm);
		dec.is_arith_reg = (opcode == op_reg);
		// sll/srl/sra in both forms, funct3 x01
		dec.is_shift = (dec.is_arith_imm || dec.is_arith_reg) && (instr[13:12] == 2'b01);
		dec.is_jal = (opcode == op_jal);
		dec.is_jalr = (opcode == op_jalr);
		dec.is_lui = (opcode == op_lui);
		dec.is_auipc = (opcode == op_auipc);

		// register fields sit at fixed positions
		dec.funct3 = instr[14:12];
		dec.alt = instr[30];
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		dec.rd = instr[11:7];

		// pick the immediate for the class
		if (dec.is_lui || dec.is_auipc) begin
			dec.imm = imm_u;
		end else if (dec.is_jal) begin
			dec.imm = imm_j;
		end else if (dec.is_branch) begin
			dec.imm = imm_b;
		end else if (dec.is_store) begin
			dec.imm = imm_s;
		end else begin
			// loads, jalr, op-imm; shamt is imm[4:0]
			dec.imm = imm_i;
		end
	end

endmodule

//--- hw/rv_regfile.sv
/*
 * 32 x 32-bit register file
 * two combinational read ports, one synchronous write port
 */
`timescale 1ns/1ns

module rv_regfile (
	input logic clock,
	input rv_core_pkg::reg_addr_t rs1,
	input rv_core_pkg::reg_addr_t rs2,
	input rv_core_pkg::reg_addr_t rd,
	input logic rd_wen,
	input rv_core_pkg::word_t wd,
	output rv_core_pkg::word_t rs1_data,
	output rv_core_pkg::word_t rs2_data
);
	import rv_core_pkg::*;

	word_t regs [2**reg_addr_w];

	always_ff @(posedge clock) begin
		if (rd_wen && rd != '0) begin
			regs[rd] <= wd;
		end
	end

	// x0 reads as zero whatever the array holds
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/rv_alu.sv
/*
 * operand selection and ALU operation choice
 * adder/logic unit, comparator, write-back data mux
 */
`timescale 1ns/1ns

module rv_alu (
	input rv_core_pkg::decoded_t dec,
	input rv_core_pkg::seq_state_e state,
	input rv_core_pkg::word_t pc,
	input rv_core_pkg::word_t rs1_data,
	input rv_core_pkg::word_t rs2_data,
	input rv_core_pkg::word_t shift_out,
	input rv_core_pkg::word_t load_data,
	output rv_core_pkg::word_t alu_out,
	output rv_core_pkg::word_t wb_data,
	output logic cmp_true
);
	import rv_core_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t cmp_b;
	alu_op_e op;
	logic is_sub;
	logic is_slt;
	logic cmp_raw;

	assign is_sub = dec.is_arith_reg && dec.funct3 == f3_add && dec.alt;
	assign is_slt = (dec.is_arith_imm || dec.is_arith_reg) &&
		(dec.funct3 == f3_slt || dec.funct3 == f3_sltu);

	always_comb begin
		if (dec.is_lui) begin
			op_a = '0;
			op_b = dec.imm;
		end else if (dec.is_auipc || dec.is_jal || dec.is_branch) begin
			// pc-relative targets
			op_a = pc;
			op_b = dec.imm;
		end else if (dec.is_arith_reg) begin
			op_a = rs1_data;
			op_b = is_sub ? (~rs2_data + 32'd1) : rs2_data;
		end else begin
			// loads, stores, jalr, op-imm
			op_a = rs1_data;
			op_b = dec.imm;
		end

		op = alu_add;
		if (dec.is_arith_imm || dec.is_arith_reg) begin
			case (dec.funct3)
				f3_xor: op = alu_xor;
				f3_or: op = alu_or;
				f3_and: op = alu_and;
				default: op = alu_add;
			endcase
		end

		case (op)
			alu_and: alu_out = op_a & op_b;
			alu_or: alu_out = op_a | op_b;
			alu_xor: alu_out = op_a ^ op_b;
			default: alu_out = op_a + op_b;
		endcase
	end

	// comparator, rs1 against rs2 or the immediate
	assign cmp_b = dec.is_arith_imm ? dec.imm : rs2_data;

	always_comb begin
		if (!dec.is_branch) begin
			cmp_raw = (dec.funct3 == f3_slt) ? ($signed(rs1_data) < $signed(cmp_b)) :
				(rs1_data < cmp_b);
		end else begin
			case (dec.funct3[2:1])
				cmp_eq: cmp_raw = (rs1_data == cmp_b);
				cmp_lt: cmp_raw = ($signed(rs1_data) < $signed(cmp_b));
				cmp_ltu: cmp_raw = (rs1_data < cmp_b);
				default: cmp_raw = 1'b0;
			endcase
		end
	end

	// bne/bge/bgeu flip the sense
	assign cmp_true = cmp_raw ^ (dec.is_branch && dec.funct3[0]);

	always_comb begin
		if (state == st_mem) begin
			wb_data = load_data;
		end else if (dec.is_jal || dec.is_jalr) begin
			// link address
			wb_data = pc + 32'd4;
		end else if (dec.is_shift) begin
			wb_data = shift_out;
		end else if (is_slt) begin
			wb_data = {31'b0, cmp_true};
		end else begin
			wb_data = alu_out;
		end
	end

endmodule

//--- hw/rv_shifter.sv
/*
 * serial shifter for sll, srl, sra
 * one bit per cycle, count loaded in decode
 */
`timescale 1ns/1ns

module rv_shifter (
	input logic clock,
	input logic reset,
	input rv_core_pkg::seq_state_e state,
	input rv_core_pkg::decoded_t dec,
	input rv_core_pkg::word_t rs1_data,
	input rv_core_pkg::word_t rs2_data,
	output rv_core_pkg::word_t shift_out,
	output logic shift_done
);
	import rv_core_pkg::*;

	word_t sreg;
	logic [4:0] count;
	logic [4:0] amount;
	shift_kind_e kind;

	// register form takes rs2[4:0], immediate form the shamt field
	assign amount = dec.is_arith_reg ? rs2_data[4:0] : dec.imm[4:0];

	always_comb begin
		if (dec.funct3 == f3_sll) begin
			kind = shift_sll;
		end else begin
			kind = dec.alt ? shift_sra : shift_srl;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (state == st_decode && dec.is_shift) begin
			count <= amount;
		end else if (state == st_shift && count != '0) begin
			count <= count - 5'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (state == st_decode && dec.is_shift) begin
			sreg <= rs1_data;
		end else if (state == st_shift && count != '0) begin
			case (kind)
				shift_sll: sreg <= {sreg[xlen-2:0], 1'b0};
				shift_sra: sreg <= {sreg[xlen-1], sreg[xlen-1:1]};
				default: sreg <= {1'b0, sreg[xlen-1:1]};
			endcase
		end
	end

	assign shift_out = sreg;
	assign shift_done = (state == st_shift) && (count == '0);

	// exhausted count hands over to execute and stays at zero
	a_no_wrap: assert property (@(posedge clock) disable iff (reset)
		(state == st_shift && count == '0) |=> (state == st_execute && count == '0));

endmodule

//--- hw/rv_lsu.sv
/*
 * load/store unit
 * store lane replication and byte strobes, load lane extraction and extension
 */
`timescale 1ns/1ns

module rv_lsu (
	input rv_core_pkg::decoded_t dec,
	input rv_core_pkg::word_t alu_out,
	input rv_core_pkg::word_t rs2_data,
	input rv_core_pkg::word_t drdata,
	output rv_core_pkg::dmem_req_t dmem_req,
	output rv_core_pkg::word_t load_data
);
	import rv_core_pkg::*;

	logic [1:0] offset;
	logic [7:0] lane_byte;
	logic [15:0] lane_half;
	logic sign_ext;

	assign offset = alu_out[1:0];
	// lbu/lhu have funct3[2] set
	assign sign_ext = !dec.funct3[2];

	// store side
	always_comb begin
		dmem_req.addr = {alu_out[xlen-1:2], 2'b00};
		dmem_req.write = dec.is_store;
		case (dec.funct3[1:0])
			size_byte: begin
				dmem_req.wdata = {4{rs2_data[7:0]}};
				dmem_req.strb = 4'b0001 << offset;
			end
			size_half: begin
				// bit 0 of the address is ignored
				dmem_req.wdata = {2{rs2_data[15:0]}};
				dmem_req.strb = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dmem_req.wdata = rs2_data;
				dmem_req.strb = 4'b1111;
			end
		endcase
	end

	// load side
	always_comb begin
		case (offset)
			2'b00: lane_byte = drdata[7:0];
			2'b01: lane_byte = drdata[15:8];
			2'b10: lane_byte = drdata[23:16];
			default: lane_byte = drdata[31:24];
		endcase
		lane_half = offset[1] ? drdata[31:16] : drdata[15:0];

		case (dec.funct3[1:0])
			size_byte: load_data = {{24{sign_ext && lane_byte[7]}}, lane_byte};
			size_half: load_data = {{16{sign_ext && lane_half[15]}}, lane_half};
			default: load_data = drdata;
		endcase
	end

endmodule

//--- hw/rv_core.sv
/*
 * multicycle RV32I core top level
 * sequencer, decoder, register file, ALU, serial shifter and load/store unit
 */
`timescale 1ns/1ns

module rv_core (
	input logic clock,
	input logic reset,
	output rv_core_pkg::word_t iaddr,
	input rv_core_pkg::word_t idata,
	output logic ivalid,
	input logic iready,
	output rv_core_pkg::dmem_req_t dmem_req,
	output logic dvalid,
	input logic dready,
	input rv_core_pkg::word_t drdata
);
	import rv_core_pkg::*;

	seq_state_e state;
	word_t pc;
	decoded_t dec;
	word_t rs1_data;
	word_t rs2_data;
	word_t alu_out;
	word_t wb_data;
	word_t shift_out;
	word_t load_data;
	logic cmp_true;
	logic shift_done;
	logic rd_wen;

	// fetch address is the pc itself
	assign iaddr = pc;

	rv_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.dec(dec),
		.iready(iready),
		.dready(dready),
		.shift_done(shift_done),
		.cmp_true(cmp_true),
		.alu_out(alu_out),
		.state(state),
		.pc(pc),
		.ivalid(ivalid),
		.dvalid(dvalid),
		.rd_wen(rd_wen)
	);

	rv_decode u_decode (
		.clock(clock),
		.reset(reset),
		.state(state),
		.idata(idata),
		.iready(iready),
		.dec(dec)
	);

	rv_regfile u_regfile (
		.clock(clock),
		.rs1(dec.rs1),
		.rs2(dec.rs2),
		.rd(dec.rd),
		.rd_wen(rd_wen),
		.wd(wb_data),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	rv_alu u_alu (
		.dec(dec),
		.state(state),
		.pc(pc),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.shift_out(shift_out),
		.load_data(load_data),
		.alu_out(alu_out),
		.wb_data(wb_data),
		.cmp_true(cmp_true)
	);

	rv_shifter u_shifter (
		.clock(clock),
		.reset(reset),
		.state(state),
		.dec(dec),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.shift_out(shift_out),
		.shift_done(shift_done)
	);

	rv_lsu u_lsu (
		.dec(dec),
		.alu_out(alu_out),
		.rs2_data(rs2_data),
		.drdata(drdata),
		.dmem_req(dmem_req),
		.load_data(load_data)
	);

endmodule

//--- testbench/rv_core_mem.sv
/*
 * instruction and data memory model for the core testbench
 * ready lines stall at random when enabled
 */
`timescale 1ns/1ns

module rv_core_mem (
	input logic clock,
	input rv_core_pkg::word_t iaddr,
	output rv_core_pkg::word_t idata,
	output logic iready,
	input rv_core_pkg::dmem_req_t dmem_req,
	input logic dvalid,
	output logic dready,
	output rv_core_pkg::word_t drdata,
	input logic stall_en,
	input logic [1:0] rnd
);
	import rv_core_pkg::*;

	// 1 KB each, word indexed
	word_t imem [256];
	word_t dmem [256];

	assign idata = imem[iaddr[9:2]];
	assign drdata = dmem[dmem_req.addr[9:2]];

	// random bits come from the testbench, one pair per cycle
	assign iready = !stall_en || rnd[0];
	assign dready = !stall_en || rnd[1];

	// byte-lane writes on the data transfer
	always @(posedge clock) begin
		if (dvalid && dready && dmem_req.write) begin
			for (int b = 0; b < 4; b++) begin
				if (dmem_req.strb[b]) begin
					dmem[dmem_req.addr[9:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
				end
			end
		end
	end

	// pattern built from the full byte address
	task fill_data();
		word_t a;
		for (int i = 0; i < 256; i++) begin
			a = i * 4;
			dmem[i] = (a * 32'h0001_0001) ^ 32'h5A5A_A5A5;
		end
	endtask

endmodule

//--- testbench/rv_core_tb.sv
/*
 * testbench for the multicycle RV32I core
 * clock, reset, instruction encoders, LCG stalls, store monitor
 * directed tests for arithmetic, shifts, loads/stores, branches, back-pressure
 */
`timescale 1ns/1ns

module rv_core_tb;
	import rv_core_pkg::*;

	localparam word_t data_base = 32'h0000_0100;
	localparam word_t load_word = 32'h8F7E_F081;
	localparam word_t nop = 32'h0000_0013;

	logic clock;
	logic reset;
	word_t iaddr;
	word_t idata;
	logic ivalid;
	logic iready;
	dmem_req_t dmem_req;
	logic dvalid;
	logic dready;
	word_t drdata;
	logic stall_en;
	logic [1:0] rnd;
	logic [31:0] lcg_state;

	// program image and expectations
	word_t prog [$];
	word_t exp_fetch [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	logic [3:0] exp_strb [$];
	int soff;

	// observed traffic
	word_t fetch_q [$];
	word_t st_addr [$];
	word_t st_data [$];
	logic [3:0] st_strb [$];

	rv_core rv_core_i (
		.clock(clock),
		.reset(reset),
		.iaddr(iaddr),
		.idata(idata),
		.ivalid(ivalid),
		.iready(iready),
		.dmem_req(dmem_req),
		.dvalid(dvalid),
		.dready(dready),
		.drdata(drdata)
	);

	rv_core_mem mem (
		.clock(clock),
		.iaddr(iaddr),
		.idata(idata),
		.iready(iready),
		.dmem_req(dmem_req),
		.dvalid(dvalid),
		.dready(dready),
		.drdata(drdata),
		.stall_en(stall_en),
		.rnd(rnd)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// new stall bits shortly after each edge, upper LCG bits
	always @(posedge clock) begin
		#1;
		lcg_state = lcg_step(lcg_state);
		rnd <= lcg_state[17:16];
	end

	// transfers are sampled on the edge itself
	always @(posedge clock) begin
		if (!reset) begin
			if (ivalid && iready) begin
				fetch_q.push_back(iaddr);
			end
			if (dvalid && dready && dmem_req.write) begin
				st_addr.push_back(dmem_req.addr);
				st_data.push_back(dmem_req.wdata);
				st_strb.push_back(dmem_req.strb);
			end
		end
	end

	task check(input string name, input logic [31:0] got, input logic [31:0] expv);
		if (got !== expv) begin
			$display("FAILED %s: got %h, expected %h", name, got, expv);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task fail_run(input string msg);
		$display("ERROR: %s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "%s", msg);
	endtask

	// instruction formats
	function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t next_pc();
		return reset_pc + 4 * prog.size();
	endfunction

	// exec marks an instruction that the core must fetch
	task put(input word_t w, input bit exec);
		if (exec) begin
			exp_fetch.push_back(next_pc());
		end
		prog.push_back(w);
	endtask

	task expect_store(input word_t addr, input word_t data, input logic [3:0] strb);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	// sw rs into the next result slot
	task put_result(input logic [4:0] rs, input word_t expv);
		put(enc_s(soff[11:0], rs, 5'd2, 3'b010), 1);
		expect_store(data_base + soff, expv, 4'hF);
		soff += 4;
	endtask

	task load_const(input logic [4:0] rd, input word_t value);
		word_t upper;
		upper = value + 32'h800;
		put(enc_u(upper[31:12], rd, 7'b0110111), 1);
		put(enc_i(value[11:0], rd, 3'b000, rd, 7'b0010011), 1);
	endtask

	task begin_program();
		prog.delete();
		exp_fetch.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_strb.delete();
		soff = 0;
		put(enc_i(12'h100, 5'd0, 3'b000, 5'd2, 7'b0010011), 1);
	endtask

	task run_program(input string name);
		int cnt;
		// trailing self-loop keeps the core busy without traffic
		put(enc_j(21'd0, 5'd0), 1);
		reset = 1'b1;
		for (int i = 0; i < 256; i++) begin
			mem.imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_006F;
		end
		mem.fill_data();
		mem.dmem[128] = load_word;
		fetch_q.delete();
		st_addr.delete();
		st_data.delete();
		st_strb.delete();
		repeat (4) begin
			@(posedge clock);
			#1;
			check("ivalid in reset", 32'(ivalid), 32'd0);
			check("dvalid in reset", 32'(dvalid), 32'd0);
		end
		reset = 1'b0;
		cnt = 0;
		while (!ivalid) begin
			@(posedge clock);
			#1;
			cnt++;
			if (cnt > 20) fail_run("no fetch request after reset");
		end
		check("iaddr", iaddr, reset_pc);
		cnt = 0;
		while (!dvalid) begin
			@(posedge clock);
			#1;
			cnt++;
			if (cnt > 2000) fail_run("no data request after reset");
		end
		check("dmem_req.write", 32'(dmem_req.write), 32'd1);
		cnt = 0;
		while (st_addr.size() < exp_addr.size()) begin
			@(posedge clock);
			#1;
			cnt++;
			if (cnt > 20000) fail_run({name, " program did not finish its stores"});
		end
		repeat (40) @(posedge clock);
		#1;
		check("store count", st_addr.size(), exp_addr.size());
		for (int i = 0; i < exp_addr.size(); i++) begin
			check("dmem_req.addr", st_addr[i], exp_addr[i]);
			check("dmem_req.wdata", st_data[i], exp_data[i]);
			check("dmem_req.strb", 32'(st_strb[i]), 32'(exp_strb[i]));
		end
		if (fetch_q.size() < exp_fetch.size()) fail_run({name, " fetched too few instructions"});
		for (int i = 0; i < exp_fetch.size(); i++) begin
			check("iaddr", fetch_q[i], exp_fetch[i]);
		end
	endtask

	task test_arith();
		word_t a;
		word_t b;
		word_t pc;
		a = 32'h8765_4321;
		b = 32'hFFFF_FFFB;
		begin_program();
		load_const(5'd1, a);
		put_result(5'd1, a);
		put(enc_i(12'hFFB, 5'd0, 3'b000, 5'd3, 7'b0010011), 1);
		put_result(5'd3, b);
		put(enc_i(12'hF00, 5'd1, 3'b000, 5'd4, 7'b0010011), 1);
		put_result(5'd4, a - 32'd256);
		put(enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd4), 1);
		put_result(5'd4, a + b);
		put(enc_r(7'h20, 5'd3, 5'd1, 3'b000, 5'd4), 1);
		put_result(5'd4, a - b);
		put(enc_r(7'h00, 5'd3, 5'd1, 3'b111, 5'd4), 1);
		put_result(5'd4, a & b);
		put(enc_r(7'h00, 5'd3, 5'd1, 3'b110, 5'd4), 1);
		put_result(5'd4, a | b);
		put(enc_r(7'h00, 5'd3, 5'd1, 3'b100, 5'd4), 1);
		put_result(5'd4, a ^ b);
		put(enc_r(7'h00, 5'd3, 5'd1, 3'b010, 5'd4), 1);
		put_result(5'd4, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		put(enc_r(7'h00, 5'd1, 5'd3, 3'b010, 5'd4), 1);
		put_result(5'd4, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		put(enc_r(7'h00, 5'd3, 5'd1, 3'b011, 5'd4), 1);
		put_result(5'd4, (a < b) ? 32'd1 : 32'd0);
		put(enc_r(7'h00, 5'd1, 5'd3, 3'b011, 5'd4), 1);
		put_result(5'd4, (b < a) ? 32'd1 : 32'd0);
		put(enc_u(20'hABCDE, 5'd4, 7'b0110111), 1);
		put_result(5'd4, 32'hABCD_E000);
		pc = next_pc();
		put(enc_u(20'h12345, 5'd4, 7'b0010111), 1);
		put_result(5'd4, pc + 32'h1234_5000);
		run_program("arithmetic");
	endtask

	task test_shift();
		word_t a;
		int amts [4];
		logic [4:0] amt;
		a = 32'h8765_4321;
		amts = '{0, 1, 17, 31};
		begin_program();
		load_const(5'd1, a);
		for (int i = 0; i < 4; i++) begin
			amt = 5'(amts[i]);
			put(enc_i({7'h00, amt}, 5'd1, 3'b001, 5'd4, 7'b0010011), 1);
			put_result(5'd4, a << amt);
			put(enc_i({7'h00, amt}, 5'd1, 3'b101, 5'd4, 7'b0010011), 1);
			put_result(5'd4, a >> amt);
			put(enc_i({7'h20, amt}, 5'd1, 3'b101, 5'd4, 7'b0010011), 1);
			put_result(5'd4, $signed(a) >>> amt);
			// upper amount bits set, only rs2[4:0] counts
			put(enc_i(12'(amts[i] + 32), 5'd0, 3'b000, 5'd5, 7'b0010011), 1);
			put(enc_r(7'h00, 5'd5, 5'd1, 3'b001, 5'd4), 1);
			put_result(5'd4, a << amt);
			put(enc_r(7'h00, 5'd5, 5'd1, 3'b101, 5'd4), 1);
			put_result(5'd4, a >> amt);
			put(enc_r(7'h20, 5'd5, 5'd1, 3'b101, 5'd4), 1);
			put_result(5'd4, $signed(a) >>> amt);
		end
		run_program("shift");
	endtask

	task test_mem();
		word_t a;
		logic [7:0] lb;
		logic [15:0] lh;
		a = 32'h8765_4321;
		begin_program();
		load_const(5'd1, a);
		for (int off = 0; off < 4; off++) begin
			put(enc_s(12'(off), 5'd1, 5'd2, 3'b000), 1);
			expect_store(data_base, {4{a[7:0]}}, 4'b0001 << off);
		end
		for (int off = 0; off < 4; off++) begin
			put(enc_s(12'(off), 5'd1, 5'd2, 3'b001), 1);
			expect_store(data_base, {2{a[15:0]}}, (off >= 2) ? 4'b1100 : 4'b0011);
		end
		put(enc_i(12'h200, 5'd0, 3'b000, 5'd7, 7'b0010011), 1);
		for (int off = 0; off < 4; off++) begin
			lb = 8'(load_word >> (8 * off));
			put(enc_i(12'(off), 5'd7, 3'b000, 5'd8, 7'b0000011), 1);
			put_result(5'd8, {{24{lb[7]}}, lb});
			put(enc_i(12'(off), 5'd7, 3'b100, 5'd8, 7'b0000011), 1);
			put_result(5'd8, {24'h0, lb});
			// halfword lane comes from address bit 1
			lh = 16'(load_word >> (16 * (off / 2)));
			put(enc_i(12'(off), 5'd7, 3'b001, 5'd8, 7'b0000011), 1);
			put_result(5'd8, {{16{lh[15]}}, lh});
			put(enc_i(12'(off), 5'd7, 3'b101, 5'd8, 7'b0000011), 1);
			put_result(5'd8, {16'h0, lh});
		end
		put(enc_i(12'd0, 5'd7, 3'b010, 5'd8, 7'b0000011), 1);
		put_result(5'd8, load_word);
		run_program("load/store");
	endtask

	function automatic bit branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return !($signed(a) < $signed(b));
			3'b110: return a < b;
			default: return !(a < b);
		endcase
	endfunction

	task test_branch();
		logic [2:0] f3s [6];
		logic [4:0] r1 [3];
		logic [4:0] r2 [3];
		word_t va;
		word_t vb;
		word_t pc;
		bit t;
		f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		r1 = '{5'd1, 5'd3, 5'd3};
		r2 = '{5'd3, 5'd1, 5'd3};
		begin_program();
		// x1 = -1, x3 = 1
		put(enc_i(12'hFFF, 5'd0, 3'b000, 5'd1, 7'b0010011), 1);
		put(enc_i(12'h001, 5'd0, 3'b000, 5'd3, 7'b0010011), 1);
		for (int f = 0; f < 6; f++) begin
			for (int p = 0; p < 3; p++) begin
				va = (r1[p] == 5'd1) ? 32'hFFFF_FFFF : 32'd1;
				vb = (r2[p] == 5'd1) ? 32'hFFFF_FFFF : 32'd1;
				t = branch_taken(f3s[f], va, vb);
				put(enc_b(13'd8, r2[p], r1[p], f3s[f]), 1);
				put(nop, !t);
			end
		end
		pc = next_pc();
		put(enc_j(21'd8, 5'd9), 1);
		put(nop, 0);
		put_result(5'd9, pc + 32'd4);
		pc = next_pc();
		put(enc_u(20'h0, 5'd10, 7'b0010111), 1);
		put(enc_i(12'd12, 5'd10, 3'b000, 5'd11, 7'b1100111), 1);
		put(nop, 0);
		put_result(5'd11, pc + 32'd8);
		run_program("branch");
	endtask

	initial begin
		reset = 1'b1;
		stall_en = 1'b0;
		rnd = 2'b11;
		lcg_state = 32'd26;
		test_arith();
		test_shift();
		test_mem();
		test_branch();
		// same programs with random ready back-pressure
		stall_en = 1'b1;
		test_arith();
		test_mem();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- rv_core.f
hw/rv_core_pkg.sv
hw/rv_sequencer.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_shifter.sv
hw/rv_lsu.sv
hw/rv_core.sv
testbench/rv_core_mem.sv
testbench/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= rv_core_tb
FLIST ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
